// ==== src/side_ch_pkg.sv ====
// side channel widths, limits, trigger/format/state/start enums, status and config structs
package side_ch_pkg;

	localparam int IQ_W = 16;
	localparam int TSF_W = 64;
	localparam int DMA_W = 64;
	localparam int GPIO_W = 8; // agc lock on top, gain below
	localparam int RSSI_W = 11; // signed, half dB steps
	localparam int CNT_W = 14;

	localparam int MAX_UDP_SYMBOLS = 8188; // 65507 byte udp payload / 8
	localparam int NUM_SYM_REG_ADDR = 2;

	typedef enum logic [3:0] {
		TRIG_FCS_ANY,
		TRIG_FCS_OK,
		TRIG_FCS_BAD,
		TRIG_RSSI_RISE,
		TRIG_RSSI_FALL,
		TRIG_AGC_UNLOCK,
		TRIG_AGC_LOCK,
		TRIG_GAIN_RISE,
		TRIG_GAIN_FALL,
		TRIG_TXBB_RISE,
		TRIG_TXBB_FALL,
		TRIG_TXRF_RISE,
		TRIG_TXRF_FALL,
		TRIG_IQ_ABOVE_TX
	} trig_sel_e;

	typedef enum logic {
		FMT_STATUS_IQ,
		FMT_DUAL_IQ
	} word_fmt_e;

	typedef enum logic [1:0] {
		CAP_WAIT,
		CAP_PREPARE,
		CAP_HEADER,
		CAP_STREAM
	} cap_state_e;

	typedef enum logic [1:0] {
		START_LOOPBACK,
		START_AUTO,
		START_EXT,
		START_OFF
	} start_mode_e;

	// I in the low half
	typedef struct packed {
		logic signed [IQ_W-1:0] q;
		logic signed [IQ_W-1:0] i;
	} iq_pair_t;

	typedef struct packed {
		logic [GPIO_W-1:0]        gpio_status;
		logic signed [RSSI_W-1:0] rssi_half_db;
		logic                     fcs_strobe;
		logic                     fcs_ok;
		logic                     tx_bb_ongoing;
		logic                     tx_rf_ongoing;
		logic                     tx_start;
	} rx_status_t;

	typedef struct packed {
		trig_sel_e         trig_sel;
		word_fmt_e         word_fmt;
		logic              free_run;
		logic [IQ_W-1:0]   iq_th; // low bits also rssi threshold
		logic [GPIO_W-2:0] gain_th;
		logic [CNT_W-1:0]  pre_len;
		logic [CNT_W-1:0]  len;
	} cap_cfg_t;

endpackage

// ==== src/iq_ring_buf.sv ====
// simple dual-port RAM with registered read for the capture ring
module iq_ring_buf import side_ch_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic              clk,
	input  logic              en,
	input  logic              we,
	input  logic [BUF_AW-1:0] waddr,
	input  logic [DMA_W-1:0]  wdata,
	input  logic [BUF_AW-1:0] raddr,
	output logic [DMA_W-1:0]  rdata
);

	logic [DMA_W-1:0] mem [2**BUF_AW];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[waddr] <= wdata;
			end
			rdata <= mem[raddr]; // old word on same-address access
		end
	end

endmodule

// ==== src/trigger_select.sv ====
// trigger_select: edge and threshold detectors with registered trigger mux
module trigger_select import side_ch_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       en,
	input  rx_status_t status,
	input  cap_cfg_t   cfg,
	input  iq_pair_t   iq1,
	output logic       trig
);

	typedef struct packed {
		logic fcs_any;
		logic fcs_good;
		logic fcs_bad;
		logic rssi_rise;
		logic rssi_fall;
		logic agc_unlock;
		logic agc_lock;
		logic gain_rise;
		logic gain_fall;
		logic txbb_rise;
		logic txbb_fall;
		logic txrf_rise;
		logic txrf_fall;
		logic iq_above;
	} trig_evt_t;

	rx_status_t               prev;
	trig_evt_t                evt;
	logic signed [RSSI_W-1:0] rssi_th;
	logic signed [RSSI_W-1:0] rssi_now;
	logic signed [RSSI_W-1:0] rssi_prev;
	logic [GPIO_W-2:0]        gain_now;
	logic [GPIO_W-2:0]        gain_prev;
	logic [IQ_W-1:0]          i_abs;

	assign rssi_th = $signed(cfg.iq_th[RSSI_W-1:0]);
	assign rssi_now = $signed(status.rssi_half_db);
	assign rssi_prev = $signed(prev.rssi_half_db);
	assign gain_now = status.gpio_status[GPIO_W-2:0];
	assign gain_prev = prev.gpio_status[GPIO_W-2:0];
	assign i_abs = iq1.i[IQ_W-1] ? (~iq1.i + 1'b1) : iq1.i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			prev <= '0;
			evt <= '0;
			trig <= 1'b0;
		end else begin
			if (en) begin
				prev <= status;
				evt.fcs_any <= status.fcs_strobe;
				evt.fcs_good <= status.fcs_strobe && status.fcs_ok;
				evt.fcs_bad <= status.fcs_strobe && !status.fcs_ok;
				evt.rssi_rise <= (rssi_prev < rssi_th) && (rssi_now >= rssi_th);
				evt.rssi_fall <= (rssi_prev >= rssi_th) && (rssi_now < rssi_th);
				evt.agc_unlock <= prev.gpio_status[GPIO_W-1] && !status.gpio_status[GPIO_W-1];
				evt.agc_lock <= !prev.gpio_status[GPIO_W-1] && status.gpio_status[GPIO_W-1];
				evt.gain_rise <= (gain_prev < cfg.gain_th) && (gain_now >= cfg.gain_th);
				evt.gain_fall <= (gain_prev >= cfg.gain_th) && (gain_now < cfg.gain_th);
				evt.txbb_rise <= !prev.tx_bb_ongoing && status.tx_bb_ongoing;
				evt.txbb_fall <= prev.tx_bb_ongoing && !status.tx_bb_ongoing;
				evt.txrf_rise <= !prev.tx_rf_ongoing && status.tx_rf_ongoing;
				evt.txrf_fall <= prev.tx_rf_ongoing && !status.tx_rf_ongoing;
				evt.iq_above <= prev.tx_bb_ongoing && (i_abs > cfg.iq_th); // own tx leaking in
			end

			if (!en) begin
				trig <= 1'b0;
			end else begin
				case (cfg.trig_sel)
					TRIG_FCS_ANY:     trig <= evt.fcs_any | cfg.free_run;
					TRIG_FCS_OK:      trig <= evt.fcs_good;
					TRIG_FCS_BAD:     trig <= evt.fcs_bad;
					TRIG_RSSI_RISE:   trig <= evt.rssi_rise;
					TRIG_RSSI_FALL:   trig <= evt.rssi_fall;
					TRIG_AGC_UNLOCK:  trig <= evt.agc_unlock;
					TRIG_AGC_LOCK:    trig <= evt.agc_lock;
					TRIG_GAIN_RISE:   trig <= evt.gain_rise;
					TRIG_GAIN_FALL:   trig <= evt.gain_fall;
					TRIG_TXBB_RISE:   trig <= evt.txbb_rise;
					TRIG_TXBB_FALL:   trig <= evt.txbb_fall;
					TRIG_TXRF_RISE:   trig <= evt.txrf_rise;
					TRIG_TXRF_FALL:   trig <= evt.txrf_fall;
					TRIG_IQ_ABOVE_TX: trig <= evt.iq_above;
					default:          trig <= 1'b0; // unused codes
				endcase
			end
		end
	end

	// stale edge flags must not leak out once capture is stopped
	a_trig_needs_en: assert property (@(posedge clk) disable iff (!rstn) !$past(en) |-> !trig)
		else $error("trig high after en was low");

endmodule

// ==== src/iq_capture_seq.sv ====
// iq_capture_seq: ring pointers, timestamp lock, room check and burst FSM
module iq_capture_seq import side_ch_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             en,
	input  cap_cfg_t         cfg,
	input  rx_status_t       status,
	input  iq_pair_t         iq0,
	input  iq_pair_t         iq1,
	input  logic             iq_strobe,
	input  logic             trig,
	input  logic [TSF_W-1:0] tsf,
	input  logic [CNT_W-1:0] m_axis_data_count,
	output logic [DMA_W-1:0] cap_word,
	output logic             cap_valid
);

	localparam int PAD_W = DMA_W - 2*IQ_W - GPIO_W - RSSI_W - 2;

	cap_state_e        state;
	logic [BUF_AW-1:0] waddr;
	logic [BUF_AW-1:0] raddr;
	logic [BUF_AW-1:0] raddr_nxt;
	logic [DMA_W-1:0]  wdata;
	logic [DMA_W-1:0]  rdata;
	logic [TSF_W-1:0]  tsf_lock;
	logic [CNT_W-1:0]  cnt;
	logic              rd_step;
	logic              no_room;

	always_comb begin
		if (cfg.word_fmt == FMT_DUAL_IQ) begin
			wdata = {iq1, iq0};
		end else begin
			wdata = {{PAD_W{1'b0}}, status.tx_start, status.rssi_half_db, status.fcs_ok,
				status.gpio_status, iq0};
		end
	end

	// ram reads ahead so back to back strobes get fresh words
	assign rd_step = en && (state == CAP_STREAM) && iq_strobe;
	assign raddr_nxt = rd_step ? raddr + 1'b1 : raddr;

	assign no_room = (MAX_UDP_SYMBOLS - int'(m_axis_data_count)) < (int'(cfg.len) + 1);

	iq_ring_buf #(
		.BUF_AW(BUF_AW)
	) u_ring (
		.clk(clk),
		.en(en),
		.we(iq_strobe),
		.waddr(waddr),
		.wdata(wdata),
		.raddr(raddr_nxt),
		.rdata(rdata)
	);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= CAP_WAIT;
			waddr <= '0;
			raddr <= '0;
			cnt <= '0;
			cap_valid <= 1'b0;
		end else if (!en) begin
			cap_valid <= 1'b0; // everything else frozen
		end else begin
			cap_valid <= 1'b0;
			raddr <= raddr_nxt;
			if (iq_strobe) begin
				waddr <= waddr + 1'b1;
			end
			case (state)
				CAP_WAIT: begin
					if (trig) begin
						raddr <= waddr - BUF_AW'(cfg.pre_len);
						state <= CAP_PREPARE;
					end
				end
				CAP_PREPARE: begin
					state <= no_room ? CAP_WAIT : CAP_HEADER;
				end
				CAP_HEADER: begin
					cap_valid <= 1'b1; // timestamp word
					cnt <= '0;
					state <= (cfg.len == '0) ? CAP_WAIT : CAP_STREAM;
				end
				CAP_STREAM: begin
					if (iq_strobe) begin
						cap_valid <= 1'b1;
						cnt <= cnt + 1'b1;
						if (cnt + 1'b1 == cfg.len) begin
							state <= CAP_WAIT;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			if (state == CAP_WAIT && trig) begin
				tsf_lock <= tsf;
			end
			if (state == CAP_HEADER) begin
				cap_word <= tsf_lock;
			end else if (rd_step) begin
				cap_word <= rdata;
			end
		end
	end

	a_valid_only_in_burst: assert property (@(posedge clk) disable iff (!rstn)
		$rose(cap_valid) |-> $past(state) inside {CAP_HEADER, CAP_STREAM})
		else $error("cap_valid rose outside header/stream");

	// zero pre_len would read the slot being written
	a_pre_len_nonzero: assert property (@(posedge clk) disable iff (!rstn)
		(en && state == CAP_WAIT && trig) |-> cfg.pre_len != '0)
		else $error("trigger accepted with pre_len of 0");

endmodule

// ==== src/dma_out_mux.sv ====
// dma_out_mux: start mode select and auto start on num-symbol register write
module dma_out_mux import side_ch_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  start_mode_e      start_mode,
	input  logic             ext_trigger,
	input  logic             reg_wr,
	input  logic [4:0]       reg_addr,
	input  logic [DMA_W-1:0] data_to_pl,
	input  logic             emptyn_to_pl,
	input  logic             s_axis_tlast,
	input  logic [DMA_W-1:0] cap_word,
	input  logic             cap_valid,
	output logic [DMA_W-1:0] data_to_ps,
	output logic             data_to_ps_valid,
	output logic             pl_ask_data,
	output logic             start_1trans
);

	logic [2:0] wr_hist; // num-symbol write seen, oldest on top
	logic       auto_start;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_hist <= '0;
		end else begin
			wr_hist <= {wr_hist[1:0], reg_wr && (reg_addr == 5'(NUM_SYM_REG_ADDR))};
		end
	end

	assign auto_start = wr_hist[1] && !wr_hist[2];

	always_comb begin
		data_to_ps = '0;
		data_to_ps_valid = 1'b0;
		pl_ask_data = 1'b0;
		start_1trans = 1'b0;
		case (start_mode)
			START_LOOPBACK: begin
				data_to_ps = data_to_pl;
				data_to_ps_valid = emptyn_to_pl;
				pl_ask_data = 1'b1;
				start_1trans = s_axis_tlast;
			end
			START_AUTO: begin
				data_to_ps = cap_word;
				data_to_ps_valid = cap_valid;
				start_1trans = auto_start;
			end
			START_EXT: begin
				data_to_ps = cap_word;
				data_to_ps_valid = cap_valid;
				start_1trans = ext_trigger;
			end
			START_OFF: ; // all zero
		endcase
	end

endmodule

// ==== src/side_ch_top.sv ====
// side_ch_top: trigger, capture sequencer and dma output selector
module side_ch_top import side_ch_pkg::*; #(
	parameter int BUF_AW = 10
) (
	input  logic             clk,
	input  logic             rstn,
	input  rx_status_t       status,
	input  cap_cfg_t         cfg,
	input  logic             iq_capture,
	input  iq_pair_t         iq0,
	input  iq_pair_t         iq1,
	input  logic             iq_strobe,
	input  logic [TSF_W-1:0] tsf,
	input  logic [CNT_W-1:0] m_axis_data_count,
	input  logic [DMA_W-1:0] data_to_pl,
	input  logic             emptyn_to_pl,
	input  logic             s_axis_tlast,
	input  start_mode_e      start_mode,
	input  logic             ext_trigger,
	input  logic             reg_wr,
	input  logic [4:0]       reg_addr,
	output logic [DMA_W-1:0] data_to_ps,
	output logic             data_to_ps_valid,
	output logic             pl_ask_data,
	output logic             start_1trans
);

	logic             trig;
	logic [DMA_W-1:0] cap_word;
	logic             cap_valid;

	trigger_select u_trig (
		.clk(clk),
		.rstn(rstn),
		.en(iq_capture),
		.status(status),
		.cfg(cfg),
		.iq1(iq1),
		.trig(trig)
	);

	iq_capture_seq #(
		.BUF_AW(BUF_AW)
	) u_seq (
		.clk(clk),
		.rstn(rstn),
		.en(iq_capture),
		.cfg(cfg),
		.status(status),
		.iq0(iq0),
		.iq1(iq1),
		.iq_strobe(iq_strobe),
		.trig(trig),
		.tsf(tsf),
		.m_axis_data_count(m_axis_data_count),
		.cap_word(cap_word),
		.cap_valid(cap_valid)
	);

	dma_out_mux u_mux (
		.clk(clk),
		.rstn(rstn),
		.start_mode(start_mode),
		.ext_trigger(ext_trigger),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl),
		.s_axis_tlast(s_axis_tlast),
		.cap_word(cap_word),
		.cap_valid(cap_valid),
		.data_to_ps(data_to_ps),
		.data_to_ps_valid(data_to_ps_valid),
		.pl_ask_data(pl_ask_data),
		.start_1trans(start_1trans)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock (period 10) and reset held low for four cycles
module tb_clk_gen (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk) rstn = 1'b1; // release away from the sampling edge
	end

endmodule

// ==== dv/side_ch_tb.sv ====
// side channel testbench with random stimulus, cycle model of capture path and output checks
module side_ch_tb import side_ch_pkg::*;;

	localparam int TEST_CYCLES = 300 + 3*1000 + 6*800 + 7*800 + 2*800 + 2*500 + 1000;

	logic clk, rstn;
	rx_status_t status;
	cap_cfg_t cfg;
	logic iq_capture, iq_strobe, emptyn_to_pl, s_axis_tlast, ext_trigger, reg_wr;
	iq_pair_t iq0, iq1;
	logic [TSF_W-1:0] tsf;
	logic [CNT_W-1:0] m_axis_data_count;
	logic [DMA_W-1:0] data_to_pl, data_to_ps;
	start_mode_e start_mode;
	logic [4:0] reg_addr;
	logic data_to_ps_valid, pl_ask_data, start_1trans;

	// model state
	rx_status_t mprev;
	logic [13:0] mevt;
	logic mtrig, exp_valid, exp_hdr, exp_auto;
	logic wr_last, auto_pend;
	cap_state_e mstate;
	int wcount, rstart, k;
	logic [DMA_W-1:0] wlog [int];
	logic [DMA_W-1:0] tsf_m, exp_word;
	int errs, nchecks, bursts, ntests;
	int dut_valids;

	tb_clk_gen u_clk (.clk(clk), .rstn(rstn));

	side_ch_top #(.BUF_AW(10)) UUT (
		.clk(clk), .rstn(rstn), .status(status), .cfg(cfg), .iq_capture(iq_capture),
		.iq0(iq0), .iq1(iq1), .iq_strobe(iq_strobe), .tsf(tsf),
		.m_axis_data_count(m_axis_data_count), .data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl), .s_axis_tlast(s_axis_tlast), .start_mode(start_mode),
		.ext_trigger(ext_trigger), .reg_wr(reg_wr), .reg_addr(reg_addr),
		.data_to_ps(data_to_ps), .data_to_ps_valid(data_to_ps_valid),
		.pl_ask_data(pl_ask_data), .start_1trans(start_1trans)
	);

	function automatic logic [DMA_W-1:0] ring_word();
		logic [DMA_W-1:0] w;
		w = '0;
		if (cfg.word_fmt == FMT_DUAL_IQ) begin
			w = {iq1, iq0};
		end else begin
			w[31:0] = iq0;
			w[39:32] = status.gpio_status;
			w[40] = status.fcs_ok;
			w[51:41] = status.rssi_half_db;
			w[52] = status.tx_start;
		end
		return w;
	endfunction

	// one flag per trigger code from current and previous status
	function automatic logic [13:0] events(rx_status_t s, rx_status_t p, iq_pair_t iq,
			cap_cfg_t c);
		logic [13:0] e;
		int th, rs, rp, gth, gs, gp, ia;
		th = int'($signed(c.iq_th[RSSI_W-1:0]));
		rs = int'(s.rssi_half_db);
		rp = int'(p.rssi_half_db);
		gth = int'(c.gain_th);
		gs = int'(s.gpio_status[GPIO_W-2:0]);
		gp = int'(p.gpio_status[GPIO_W-2:0]);
		ia = int'(iq.i);
		if (ia < 0) ia = -ia;
		e[TRIG_FCS_ANY] = s.fcs_strobe;
		e[TRIG_FCS_OK] = s.fcs_strobe && s.fcs_ok;
		e[TRIG_FCS_BAD] = s.fcs_strobe && !s.fcs_ok;
		e[TRIG_RSSI_RISE] = rp < th && rs >= th;
		e[TRIG_RSSI_FALL] = rp >= th && rs < th;
		e[TRIG_AGC_UNLOCK] = p.gpio_status[GPIO_W-1] && !s.gpio_status[GPIO_W-1];
		e[TRIG_AGC_LOCK] = !p.gpio_status[GPIO_W-1] && s.gpio_status[GPIO_W-1];
		e[TRIG_GAIN_RISE] = gp < gth && gs >= gth;
		e[TRIG_GAIN_FALL] = gp >= gth && gs < gth;
		e[TRIG_TXBB_RISE] = !p.tx_bb_ongoing && s.tx_bb_ongoing;
		e[TRIG_TXBB_FALL] = p.tx_bb_ongoing && !s.tx_bb_ongoing;
		e[TRIG_TXRF_RISE] = !p.tx_rf_ongoing && s.tx_rf_ongoing;
		e[TRIG_TXRF_FALL] = p.tx_rf_ongoing && !s.tx_rf_ongoing;
		e[TRIG_IQ_ABOVE_TX] = p.tx_bb_ongoing && ia > int'(c.iq_th);
		return e;
	endfunction

	function automatic logic pick(logic [13:0] e, cap_cfg_t c);
		if (c.trig_sel > TRIG_IQ_ABOVE_TX) return 1'b0; // unlisted codes
		return e[c.trig_sel] | (c.trig_sel == TRIG_FCS_ANY && c.free_run);
	endfunction

	always @(posedge clk) begin : model
		int w0;
		logic wr_now;
		if (!rstn) begin
			mprev = '0;
			mevt = '0;
			mtrig = 1'b0;
			mstate = CAP_WAIT;
			wcount = 0;
			wr_last = 1'b0;
			auto_pend = 1'b0;
			exp_valid = 1'b0;
			exp_hdr = 1'b0;
			exp_auto = 1'b0;
		end else begin
			// a new write is seen here, the pulse follows one edge later
			wr_now = reg_wr && reg_addr == 5'd2;
			exp_auto = auto_pend;
			auto_pend = wr_now && !wr_last;
			wr_last = wr_now;
			exp_valid = 1'b0;
			exp_hdr = 1'b0;
			if (iq_capture) begin
				w0 = wcount;
				if (iq_strobe) begin
					wlog[wcount] = ring_word();
					wcount++;
				end
				case (mstate)
					CAP_WAIT: if (mtrig) begin
						rstart = w0 - int'(cfg.pre_len);
						tsf_m = tsf;
						mstate = CAP_PREPARE;
					end
					CAP_PREPARE: mstate = (MAX_UDP_SYMBOLS - int'(m_axis_data_count)
						< int'(cfg.len) + 1) ? CAP_WAIT : CAP_HEADER;
					CAP_HEADER: begin
						exp_valid = 1'b1;
						exp_hdr = 1'b1;
						exp_word = tsf_m;
						k = 0;
						mstate = (cfg.len == '0) ? CAP_WAIT : CAP_STREAM;
					end
					CAP_STREAM: if (iq_strobe) begin
						exp_valid = 1'b1;
						exp_word = wlog[rstart + k];
						k++;
						if (k == int'(cfg.len)) mstate = CAP_WAIT;
					end
				endcase
				mtrig = pick(mevt, cfg);
				mevt = events(status, mprev, iq1, cfg);
				mprev = status;
			end else begin
				mtrig = 1'b0;
			end
		end
	end

	task automatic report_mismatch(string name, logic [DMA_W-1:0] exp, logic [DMA_W-1:0] got);
		$display("ERR %s exp %h got %h", name, exp, got);
		errs++;
	endtask

	task automatic check_outputs();
		if (!rstn) return;
		nchecks++;
		if (exp_hdr) bursts++;
		case (start_mode)
			START_LOOPBACK: begin
				if (data_to_ps !== data_to_pl)
					report_mismatch("data_to_ps", data_to_pl, data_to_ps);
				if (data_to_ps_valid !== emptyn_to_pl)
					report_mismatch("data_to_ps_valid", 64'(emptyn_to_pl), 64'(data_to_ps_valid));
				if (pl_ask_data !== 1'b1)
					report_mismatch("pl_ask_data", 64'd1, 64'(pl_ask_data));
				if (start_1trans !== s_axis_tlast)
					report_mismatch("start_1trans", 64'(s_axis_tlast), 64'(start_1trans));
			end
			START_OFF: begin
				if (data_to_ps !== '0) report_mismatch("data_to_ps", 64'd0, data_to_ps);
				if (data_to_ps_valid !== 1'b0)
					report_mismatch("data_to_ps_valid", 64'd0, 64'(data_to_ps_valid));
				if (pl_ask_data !== 1'b0)
					report_mismatch("pl_ask_data", 64'd0, 64'(pl_ask_data));
				if (start_1trans !== 1'b0)
					report_mismatch("start_1trans", 64'd0, 64'(start_1trans));
			end
			default: begin
				if (data_to_ps_valid === 1'b1) dut_valids++;
				if (data_to_ps_valid !== exp_valid)
					report_mismatch("data_to_ps_valid", 64'(exp_valid), 64'(data_to_ps_valid));
				if (exp_valid && data_to_ps !== exp_word)
					report_mismatch("data_to_ps", exp_word, data_to_ps);
				if (start_mode == START_AUTO && start_1trans !== exp_auto)
					report_mismatch("start_1trans", 64'(exp_auto), 64'(start_1trans));
				if (start_mode == START_EXT && start_1trans !== ext_trigger)
					report_mismatch("start_1trans", 64'(ext_trigger), 64'(start_1trans));
			end
		endcase
	endtask

	// status hovers around the configured thresholds so crossings are common
	task automatic drive_random();
		int th, gain, rssi;
		th = int'($signed(cfg.iq_th[RSSI_W-1:0]));
		tsf = tsf + 64'd1;
		iq0 = $urandom;
		iq1 = $urandom;
		iq_strobe = 1'($urandom % 2);
		rssi = th + int'($urandom % 41) - 20;
		status.rssi_half_db = RSSI_W'(rssi);
		gain = int'(cfg.gain_th) + int'($urandom % 9) - 4;
		status.gpio_status[GPIO_W-2:0] = 7'(gain);
		if ($urandom % 8 == 0) status.gpio_status[GPIO_W-1] = !status.gpio_status[GPIO_W-1];
		if ($urandom % 8 == 0) status.tx_bb_ongoing = !status.tx_bb_ongoing;
		if ($urandom % 8 == 0) status.tx_rf_ongoing = !status.tx_rf_ongoing;
		status.fcs_strobe = ($urandom % 8 == 0);
		status.fcs_ok = 1'($urandom % 2);
		status.tx_start = ($urandom % 16 == 0);
		data_to_pl = {$urandom, $urandom};
		emptyn_to_pl = 1'($urandom % 2);
		s_axis_tlast = ($urandom % 4 == 0);
		ext_trigger = ($urandom % 4 == 0);
		reg_wr = ($urandom % 8 == 0);
		reg_addr = 5'($urandom % 4);
	endtask

	task automatic step();
		@(negedge clk);
		check_outputs(); // before new inputs change the mux outputs
		drive_random();
	endtask

	task automatic set_cfg(trig_sel_e sel, word_fmt_e fmt, logic fr);
		while (mstate != CAP_WAIT) step();
		cfg.trig_sel = sel;
		cfg.word_fmt = fmt;
		cfg.free_run = fr;
		cfg.iq_th = 16'($urandom % 4096);
		cfg.gain_th = 7'($urandom % 128);
		cfg.pre_len = 14'(2 + $urandom % 60);
		cfg.len = 14'($urandom % 41);
	endtask

	task automatic run_test(string name, int cycles, bit need_burst, bit no_burst);
		int e0, b0, v0;
		e0 = errs;
		b0 = bursts;
		v0 = dut_valids;
		repeat (cycles) step();
		if (need_burst && bursts == b0) begin
			$display("%s: no burst was captured", name);
			errs++;
		end
		if (no_burst && dut_valids != v0) begin
			$display("%s: the DUT sent words without room in the DMA FIFO", name);
			errs++;
		end
		ntests++;
		$display("test %s  %s  bursts %0d  errors %0d", name,
			(errs == e0) ? "ok" : "FAIL", bursts - b0, errs - e0);
	endtask

	initial begin
		int sel3 [7];
		void'($urandom(62));
		sel3 = '{1, 2, 9, 10, 11, 12, 13};
		status = '0;
		cfg = '0;
		cfg.trig_sel = trig_sel_e'(4'hf); // never fires during warm-up
		iq_capture = 1'b0;
		iq0 = '0;
		iq1 = '0;
		iq_strobe = 1'b0;
		tsf = '0;
		m_axis_data_count = '0;
		data_to_pl = '0;
		emptyn_to_pl = 1'b0;
		s_axis_tlast = 1'b0;
		start_mode = START_EXT;
		ext_trigger = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		wait (rstn === 1'b1);

		iq_capture = 1'b1;
		repeat (300) step(); // fill the ring past any pre_len
		for (int i = 0; i < 3; i++) begin
			set_cfg(TRIG_FCS_ANY, FMT_DUAL_IQ, 1'b1);
			run_test($sformatf("free_run dual %0d", i), 1000, 1, 0);
		end
		for (int s = 3; s <= 8; s++) begin
			set_cfg(trig_sel_e'(4'(s)), FMT_STATUS_IQ, 1'b0);
			run_test($sformatf("status sel %0d", s), 800, 1, 0);
		end
		foreach (sel3[i]) begin
			set_cfg(trig_sel_e'(4'(sel3[i])), FMT_STATUS_IQ, 1'b0);
			run_test($sformatf("tx/fcs sel %0d", sel3[i]), 800, 1, 0);
		end
		set_cfg(TRIG_FCS_ANY, FMT_DUAL_IQ, 1'b1);
		m_axis_data_count = 14'(MAX_UDP_SYMBOLS - int'(cfg.len)); // room is len only
		run_test("no room", 800, 0, 1);
		m_axis_data_count = '0;
		run_test("room again", 800, 1, 0);
		start_mode = START_LOOPBACK;
		run_test("loopback", 500, 0, 0);
		start_mode = START_OFF;
		run_test("off", 500, 0, 0);
		start_mode = START_AUTO;
		run_test("auto start", 1000, 0, 0);

		$display("tests %0d  checks %0d  errors %0d", ntests, nchecks, errs);
		if (errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#((TEST_CYCLES + 5000) * 10);
		$display("watchdog: the run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== side_ch.f ====
src/side_ch_pkg.sv
src/iq_ring_buf.sv
src/trigger_select.sv
src/iq_capture_seq.sv
src/dma_out_mux.sv
src/side_ch_top.sv
dv/tb_clk_gen.sv
dv/side_ch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the side channel testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f side_ch.f --top-module side_ch_tb \
	-o side_ch_sim || { echo "verilator build failed"; exit 1; }

./obj_dir/side_ch_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
